// ==== source/agu_types_pkg.sv ====
package agu_types_pkg;

   //////////////////////////////////////////////////////////////////////
   // operations

   typedef enum logic [1:0] {
      OP_ADDR = 2'd0,                 // rs1 + imm
      OP_JUMP = 2'd1,                 // rs1 + imm with imm bit 0 cleared
      OP_SHR  = 2'd2                  // logical or arithmetic rs1 >> shamt
   } agu_op_e;

   //////////////////////////////////////////////////////////////////////
   // immediate word and its shift view

   typedef struct packed {
      logic [6:0]  funct7;            // bit 5 set for arithmetic shift
      logic [4:0]  shamt;
      logic [19:0] rest;
   } agu_shift_view_s;

   typedef union packed {
      logic [31:0]     raw;           // address operations
      agu_shift_view_s sh;            // shift operation
   } agu_imm_u;

   //////////////////////////////////////////////////////////////////////
   // request and response

   typedef struct packed {
      agu_op_e     op;
      logic [31:0] rs1;
      agu_imm_u    imm;
   } agu_req_s;

   typedef struct packed {
      logic [31:0] word;
      logic [1:0]  lsb;               // low address bits of the sum
   } agu_rsp_s;

endpackage

// ==== source/serial_ctl_pkg.sv ====
package serial_ctl_pkg;

   typedef enum logic [2:0] {
      IDLE  = 3'd0,
      LOAD  = 3'd1,                   // operands streamed through the adder
      SHIFT = 3'd2,                   // one digit right per cycle
      FINE  = 3'd3,                   // remaining shamt mod W
      DONE  = 3'd4                    // waiting on the result slot
   } seq_phase_e;

   // per-cycle controls from the sequencer
   typedef struct packed {
      logic       cnt0;               // first digit of LOAD
      logic       cnt1;               // second digit of LOAD
      logic       cnt_done;           // last LOAD digit, and the FINE cycle
      logic       en;
      logic       init;               // high in LOAD only
      logic       clr_lsb;
      logic       shift_op;
      logic       sh_signed;
      logic [2:0] shamt_fine;
   } seq_ctl_s;

endpackage

// ==== source/req_unpacker.sv ====
`timescale 1ns/1ps

module req_unpacker #(
   parameter int W = 1
) (
   input  logic                      i_clk,
   input  logic                      i_arst_n,
   input  logic                      i_req_valid,
   input  agu_types_pkg::agu_req_s   i_req,
   output logic                      o_req_ready,
   input  serial_ctl_pkg::seq_ctl_s  i_ctl,
   input  logic                      i_take,
   output logic                      o_act_valid,
   output agu_types_pkg::agu_req_s   o_act_req,
   output logic [W-1:0]              o_rs1_dig,
   output logic [W-1:0]              o_imm_dig
);

   import agu_types_pkg::*;

   agu_req_s      mem_q [2];
   logic          wr_ptr_q;
   logic          rd_ptr_q;
   logic [1:0]    count_q;
   logic          push;
   logic          pop;
   logic          head_load;
   agu_req_s      head_src;
   logic [31:0]   rs1_sr;
   logic [31:0]   imm_sr;

   assign o_req_ready = (count_q != 2'd2);
   assign push        = i_req_valid & o_req_ready;
   assign pop         = i_take;
   assign o_act_valid = (count_q != 2'd0);
   assign o_act_req   = mem_q[rd_ptr_q];

   //////////////////////////////////////////////////////////////////////
   // two-entry request FIFO

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end else begin
         if (push) wr_ptr_q <= ~wr_ptr_q;
         if (pop) rd_ptr_q <= ~rd_ptr_q;
         count_q <= count_q + 2'(push) - 2'(pop);
      end
   end

   always_ff @(posedge i_clk) begin
      if (push) mem_q[wr_ptr_q] <= i_req;
   end

   //////////////////////////////////////////////////////////////////////
   // operand digits of the active entry

   always_comb begin
      head_load = 1'b0;
      head_src  = i_req;
      if (pop && count_q == 2'd2) begin
         head_load = 1'b1;                      // waiting entry moves up
         head_src  = mem_q[~rd_ptr_q];
      end else if (push && (count_q == 2'd0 || (pop && count_q == 2'd1))) begin
         head_load = 1'b1;                      // incoming request is next
      end
   end

   always_ff @(posedge i_clk) begin
      if (head_load) begin
         rs1_sr <= head_src.rs1;
         imm_sr <= head_src.imm.raw;
      end else if (i_ctl.en && i_ctl.init) begin
         rs1_sr <= {{W{1'b0}}, rs1_sr[31:W]};
         imm_sr <= {{W{imm_sr[31]}}, imm_sr[31:W]};
      end
   end

   assign o_rs1_dig = rs1_sr[W-1:0];
   assign o_imm_dig = imm_sr[W-1:0];

   a_take_needs_active : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      i_take |-> o_act_valid
   );

endmodule

// ==== source/serial_sequencer.sv ====
`timescale 1ns/1ps

module serial_sequencer #(
   parameter int W = 1
) (
   input  logic                      i_clk,
   input  logic                      i_arst_n,
   input  logic                      i_act_valid,
   input  agu_types_pkg::agu_req_s   i_act_req,
   input  logic                      i_rsp_busy,
   output serial_ctl_pkg::seq_ctl_s  o_ctl,
   output logic                      o_take,
   output logic                      o_rsp_load
);

   import agu_types_pkg::*;
   import serial_ctl_pkg::*;

   localparam int         LOG_W     = $clog2(W);
   localparam logic [4:0] LAST_DIG  = 5'(32 / W - 1);
   localparam logic [2:0] FINE_MASK = 3'(W - 1);

   seq_phase_e  state_q, state_d, phase;
   logic [4:0]  cnt_q, cnt_d;
   logic        start;
   logic        is_shift;
   logic        last_dig;
   logic        last_step;
   logic [4:0]  shamt;
   logic [4:0]  n_steps;

   assign is_shift  = (i_act_req.op == OP_SHR);
   assign shamt     = i_act_req.imm.sh.shamt;
   assign n_steps   = shamt >> LOG_W;            // whole digits to move
   assign last_dig  = (cnt_q == LAST_DIG);
   assign last_step = (cnt_q == n_steps - 5'd1);

   // first LOAD digit overlaps the cycle the request turns up
   assign start = (state_q == IDLE || state_q == DONE) && i_act_valid && !i_rsp_busy;
   assign phase = start ? LOAD : state_q;

   //////////////////////////////////////////////////////////////////////
   // phase machine

   always_comb begin
      state_d    = state_q;
      cnt_d      = cnt_q;
      o_take     = 1'b0;
      o_rsp_load = 1'b0;
      case (phase)
         IDLE: state_d = IDLE;
         LOAD: begin
            state_d = LOAD;
            cnt_d   = cnt_q + 5'd1;
            if (last_dig) begin
               cnt_d = 5'd0;
               if (!is_shift) begin
                  state_d    = DONE;
                  o_take     = 1'b1;
                  o_rsp_load = 1'b1;
               end else if (n_steps == 5'd0) begin
                  state_d = FINE;
               end else begin
                  state_d = SHIFT;
               end
            end
         end
         SHIFT: begin
            cnt_d = cnt_q + 5'd1;
            if (last_step) begin
               cnt_d   = 5'd0;
               state_d = FINE;
            end
         end
         FINE: begin
            state_d    = DONE;
            o_take     = 1'b1;
            o_rsp_load = 1'b1;
         end
         DONE: if (!i_rsp_busy) state_d = IDLE;   // slot still held otherwise
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= IDLE;
         cnt_q   <= 5'd0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // controls to the datapath

   always_comb begin
      o_ctl.cnt0       = (phase == LOAD) && (cnt_q == 5'd0);
      o_ctl.cnt1       = (phase == LOAD) && (cnt_q == 5'd1);
      o_ctl.cnt_done   = ((phase == LOAD) && last_dig) || (phase == FINE);
      o_ctl.en         = (phase == LOAD) || (phase == SHIFT) || (phase == FINE);
      o_ctl.init       = (phase == LOAD);
      o_ctl.clr_lsb    = (i_act_req.op == OP_JUMP);
      o_ctl.shift_op   = is_shift;
      o_ctl.sh_signed  = is_shift & i_act_req.imm.sh.funct7[5];
      o_ctl.shamt_fine = shamt[2:0] & FINE_MASK;
   end

   a_shift_only_for_shr : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (state_q == SHIFT) |-> is_shift
   );

   a_take_single_pulse : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      o_take |=> !o_take
   );

endmodule

// ==== source/serial_bufreg.sv ====
`timescale 1ns/1ps

module serial_bufreg #(
   parameter int W = 1
) (
   input  logic                      i_clk,
   input  logic                      i_arst_n,
   input  serial_ctl_pkg::seq_ctl_s  i_ctl,
   input  logic [W-1:0]              i_rs1_dig,
   input  logic [W-1:0]              i_imm_dig,
   output agu_types_pkg::agu_rsp_s   o_rsp
);

   logic          load;
   logic          coarse;
   logic          fine;
   logic          fill;
   logic [W-1:0]  clr_mask;
   logic [W-1:0]  imm_g;
   logic [W-1:0]  q;
   logic          c;
   logic          c_q;
   logic [31:0]   data_q;
   logic [31:0]   data_d;
   logic [32:0]   fine_ext;
   logic [1:0]    lsb_q;

   assign load   = i_ctl.en & i_ctl.init;
   assign coarse = i_ctl.en & ~i_ctl.init & ~i_ctl.cnt_done;
   assign fine   = i_ctl.en & ~i_ctl.init & i_ctl.cnt_done;

   //////////////////////////////////////////////////////////////////////
   // serial adder

   assign clr_mask = W'(i_ctl.cnt0 & i_ctl.clr_lsb);       // jump target bit 0
   assign imm_g    = i_ctl.shift_op ? '0 : (i_imm_dig & ~clr_mask);

   assign {c, q} = {1'b0, i_rs1_dig} + {1'b0, imm_g} + (W+1)'(c_q);

   // carry dropped after the top digit so the next load starts clean
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         c_q <= 1'b0;
      end else begin
         c_q <= load & ~i_ctl.cnt_done & c;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data register, coarse and fine right shift

   assign fill     = i_ctl.sh_signed & data_q[31];
   assign fine_ext = $signed({fill, data_q}) >>> i_ctl.shamt_fine;

   always_comb begin
      data_d = data_q;
      if (load) begin
         data_d = {q, data_q[31:W]};                     // sum enters at the top
      end else if (coarse) begin
         data_d = {{W{fill}}, data_q[31:W]};
      end else if (fine) begin
         data_d = fine_ext[31:0];
      end
   end

   always_ff @(posedge i_clk) begin
      data_q <= data_d;
   end

   generate
      if (W == 1) begin : g_lsb_serial
         always_ff @(posedge i_clk) begin
            if (load && i_ctl.cnt0) lsb_q[0] <= q[0];
            if (load && i_ctl.cnt1) lsb_q[1] <= q[0];
         end
      end else begin : g_lsb_digit
         always_ff @(posedge i_clk) begin
            if (load && i_ctl.cnt0) lsb_q <= q[1:0];   // both bits in digit 0
         end
      end
   endgenerate

   // result taken from the register input so the final step is included
   assign o_rsp = '{
      word: i_ctl.shift_op ? data_d : {data_d[31:2], 2'b00},
      lsb:  lsb_q
   };

   a_carry_clear_at_start : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (load && i_ctl.cnt0) |-> (c_q == 1'b0)
   );

endmodule

// ==== source/result_port.sv ====
`timescale 1ns/1ps

module result_port (
   input  logic                     i_clk,
   input  logic                     i_arst_n,
   input  logic                     i_load,
   input  agu_types_pkg::agu_rsp_s  i_rsp,
   output logic                     o_busy,
   output logic                     o_rsp_valid,
   output agu_types_pkg::agu_rsp_s  o_rsp,
   input  logic                     i_rsp_ready
);

   import agu_types_pkg::*;

   logic      valid_q;
   agu_rsp_s  slot_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         valid_q <= 1'b0;
      end else if (i_load) begin
         valid_q <= 1'b1;
      end else if (i_rsp_ready) begin
         valid_q <= 1'b0;                      // accepted downstream
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_load) slot_q <= i_rsp;
   end

   assign o_busy      = valid_q & ~i_rsp_ready;   // slot frees up this cycle otherwise
   assign o_rsp_valid = valid_q;
   assign o_rsp       = slot_q;

   a_rsp_stable : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp))
   );

endmodule

// ==== source/serial_agu_top.sv ====
`timescale 1ns/1ps

module serial_agu_top #(
   parameter int W = 4                          // digit width of 1, 2, 4 or 8 bits
) (
   input  logic                     i_clk,
   input  logic                     i_arst_n,
   input  logic                     i_req_valid,
   input  agu_types_pkg::agu_req_s  i_req,
   output logic                     o_req_ready,
   output logic                     o_rsp_valid,
   output agu_types_pkg::agu_rsp_s  o_rsp,
   input  logic                     i_rsp_ready
);

   import agu_types_pkg::*;
   import serial_ctl_pkg::*;

   agu_req_s      act_req;
   agu_rsp_s      buf_rsp;
   seq_ctl_s      ctl;
   logic          act_valid;
   logic          take;
   logic          rsp_load;
   logic          rsp_busy;
   logic [W-1:0]  rs1_dig;
   logic [W-1:0]  imm_dig;

   //////////////////////////////////////////////////////////////////////
   // input side, processing, output side

   req_unpacker #(.W(W)) u_unpacker (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_req_valid(i_req_valid),
      .i_req      (i_req),
      .o_req_ready(o_req_ready),
      .i_ctl      (ctl),
      .i_take     (take),
      .o_act_valid(act_valid),
      .o_act_req  (act_req),
      .o_rs1_dig  (rs1_dig),
      .o_imm_dig  (imm_dig)
   );

   serial_sequencer #(.W(W)) u_sequencer (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_act_valid(act_valid),
      .i_act_req  (act_req),
      .i_rsp_busy (rsp_busy),
      .o_ctl      (ctl),
      .o_take     (take),
      .o_rsp_load (rsp_load)
   );

   serial_bufreg #(.W(W)) u_bufreg (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_ctl    (ctl),
      .i_rs1_dig(rs1_dig),
      .i_imm_dig(imm_dig),
      .o_rsp    (buf_rsp)
   );

   result_port u_result (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_load     (rsp_load),
      .i_rsp      (buf_rsp),
      .o_busy     (rsp_busy),
      .o_rsp_valid(o_rsp_valid),
      .o_rsp      (o_rsp),
      .i_rsp_ready(i_rsp_ready)
   );

endmodule

// ==== sim/agu_ref_model.svh ====
`ifndef AGU_REF_MODEL_SVH
`define AGU_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// expected response of one request

function automatic agu_rsp_s expect_rsp(input agu_req_s req);
   logic [31:0] imm;
   logic [31:0] sum;
   agu_rsp_s    rsp;
   imm = req.imm.raw;
   if (req.op == OP_SHR) begin
      if (req.imm.sh.funct7[5]) begin
         rsp.word = $signed(req.rs1) >>> req.imm.sh.shamt;   // arithmetic
      end else begin
         rsp.word = req.rs1 >> req.imm.sh.shamt;
      end
      rsp.lsb = req.rs1[1:0];                                // sum with zero imm
   end else begin
      if (req.op == OP_JUMP) begin
         imm[0] = 1'b0;                                      // jump target alignment
      end
      sum      = req.rs1 + imm;
      rsp.word = {sum[31:2], 2'b00};
      rsp.lsb  = sum[1:0];
   end
   return rsp;
endfunction

//////////////////////////////////////////////////////////////////////
// random request of any of the three operations

function automatic agu_req_s random_req(inout integer seed);
   agu_req_s    req;
   logic [31:0] pick;
   pick        = $random(seed);
   req.op      = agu_op_e'(2'(pick % 32'd3));
   req.rs1     = $random(seed);
   req.imm.raw = $random(seed);                              // shamt and funct7 too
   return req;
endfunction

`endif

// ==== sim/tb_serial_agu_top.sv ====
`timescale 1ns/1ps

module tb_serial_agu_top;

   import agu_types_pkg::*;

   `include "agu_ref_model.svh"

   localparam int W           = 4;
   localparam int N_FIXED     = 8;
   localparam int N_ADDR      = N_FIXED + 31;
   localparam int N_JUMP      = 6;
   localparam int N_SHIFT     = 128;
   localparam int N_RAND      = 300;
   localparam int N_REQ       = 1 + N_ADDR + N_JUMP + N_SHIFT + N_RAND;
   localparam int CYCLE_LIMIT = 40 * N_REQ + 200;
   localparam int DRAIN_MAX   = 400;

   localparam logic [31:0] ADDR_RS1 [N_FIXED] = '{
      32'h0000_000F, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h1234_5678,
      32'h0000_0001, 32'h5555_5555, 32'hFFFF_FFFE, 32'h8000_0001
   };
   localparam logic [31:0] ADDR_IMM [N_FIXED] = '{
      32'h0000_0001, 32'h0000_0001, 32'h0000_0001, 32'h1111_1111,
      32'h0000_0002, 32'hAAAA_AAAB, 32'hFFFF_FFFF, 32'h8000_0002
   };
   localparam logic [31:0] JUMP_RS1 [N_JUMP] = '{
      32'h0000_1000, 32'h0000_0003, 32'h1234_5679,
      32'hFFFF_FFF0, 32'h0000_0000, 32'h7FFF_FFFF
   };
   localparam logic [31:0] JUMP_IMM [N_JUMP] = '{
      32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0011,
      32'h0000_000F, 32'hFFFF_FFFF, 32'h0000_0001
   };

   logic      i_clk       = 1'b0;
   logic      i_rsp_ready = 1'b1;
   logic      i_arst_n;
   logic      i_req_valid;
   agu_req_s  i_req;
   logic      o_req_ready;
   logic      o_rsp_valid;
   agu_rsp_s  o_rsp;

   agu_rsp_s  exp_q [$];
   agu_req_s  rand_reqs [N_RAND];
   integer    seed           = 32'hc88a;
   integer    rnd;
   int        err_cnt        = 0;
   int        n_checked      = 0;
   int        cycle_cnt      = 0;
   int        hs_cycle       = 0;
   int        lat_meas       = 0;
   logic      rsp_valid_prev = 1'b0;
   logic      bp_on          = 1'b0;

   serial_agu_top #(.W(W)) i_dut (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_req_valid(i_req_valid),
      .i_req      (i_req),
      .o_req_ready(o_req_ready),
      .o_rsp_valid(o_rsp_valid),
      .o_rsp      (o_rsp),
      .i_rsp_ready(i_rsp_ready)
   );

   always #5 i_clk = ~i_clk;

   //////////////////////////////////////////////////////////////////////
   // helpers

   function automatic agu_req_s build_req(input agu_op_e op, input logic [31:0] rs1,
                                          input logic [31:0] imm);
      agu_req_s req;
      req.op      = op;
      req.rs1     = rs1;
      req.imm.raw = imm;
      return req;
   endfunction

   // called on a falling edge, returns on the falling edge after the handshake
   task automatic send_req(input agu_req_s req);
      i_req       = req;
      i_req_valid = 1'b1;
      @(posedge i_clk);
      while (!o_req_ready) @(posedge i_clk);
      @(negedge i_clk);
      i_req_valid = 1'b0;
   endtask

   task automatic wait_for_responses();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_MAX) begin
         @(negedge i_clk);
         n++;
      end
      assert (exp_q.size() == 0) else begin
         $display("%0t: %0d responses missing after the drain wait", $time, exp_q.size());
         err_cnt++;
      end
   endtask

   task automatic check_rsp();
      agu_rsp_s exp;
      assert (exp_q.size() != 0) else begin
         $display("%0t: response arrived with no request outstanding", $time);
         err_cnt++;
      end
      if (exp_q.size() != 0) begin
         exp = exp_q.pop_front();
         n_checked++;
         assert (o_rsp.word == exp.word) else begin
            $display("[ERROR] %0t o_rsp.word expected %h got %h", $time, exp.word, o_rsp.word);
            err_cnt++;
         end
         assert (o_rsp.lsb == exp.lsb) else begin
            $display("[ERROR] %0t o_rsp.lsb expected %b got %b", $time, exp.lsb, o_rsp.lsb);
            err_cnt++;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // scoreboard, back-pressure and run limit

   always @(posedge i_clk) begin
      if (i_arst_n) begin
         if (i_req_valid && o_req_ready) begin
            exp_q.push_back(expect_rsp(i_req));
            hs_cycle = cycle_cnt;
         end
         if (o_rsp_valid && !rsp_valid_prev) lat_meas = cycle_cnt - hs_cycle;
         if (o_rsp_valid && i_rsp_ready) check_rsp();
         rsp_valid_prev = o_rsp_valid;
      end
   end

   always @(negedge i_clk) begin
      if (bp_on) begin
         rnd         = $random(seed);
         i_rsp_ready = rnd[0];
      end else begin
         i_rsp_ready = 1'b1;
      end
   end

   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d responses outstanding",
                  cycle_cnt, exp_q.size());
         $display("STATUS: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus

   initial begin
      agu_req_s req;
      i_arst_n    = 1'b0;
      i_req_valid = 1'b0;
      i_req       = '0;
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_arst_n = 1'b1;

      repeat (6) begin                                 // quiet after reset
         @(negedge i_clk);
         assert (!o_rsp_valid) else begin
            $display("[ERROR] %0t o_rsp_valid expected 0 got %b", $time, o_rsp_valid);
            err_cnt++;
         end
         assert (o_req_ready) else begin
            $display("[ERROR] %0t o_req_ready expected 1 got %b", $time, o_req_ready);
            err_cnt++;
         end
      end

      send_req(build_req(OP_ADDR, 32'h0000_1234, 32'h0000_0F0F));
      wait_for_responses();
      assert (lat_meas == 32 / W + 1) else begin
         $display("[ERROR] %0t rsp latency expected %0d got %0d", $time, 32 / W + 1, lat_meas);
         err_cnt++;
      end

      for (int i = 0; i < N_FIXED; i++) send_req(build_req(OP_ADDR, ADDR_RS1[i], ADDR_IMM[i]));
      for (int b = 1; b < 32; b++) begin
         send_req(build_req(OP_ADDR, (32'h1 << b) - 32'h1, 32'h1));   // carry up to bit b
      end
      for (int i = 0; i < N_JUMP; i++) send_req(build_req(OP_JUMP, JUMP_RS1[i], JUMP_IMM[i]));
      wait_for_responses();

      for (int n = 0; n < 2; n++) begin
         for (int a = 0; a < 2; a++) begin
            for (int s = 0; s < 32; s++) begin
               req = build_req(OP_SHR, (n == 0) ? 32'h8F3C_A5E1 : 32'h6A5C_3E17, 32'h0);
               req.imm.sh.funct7 = (a == 1) ? 7'h20 : 7'h00;
               req.imm.sh.shamt  = 5'(s);
               req.imm.sh.rest   = 20'h00513;
               send_req(req);
            end
         end
      end
      wait_for_responses();

      for (int i = 0; i < N_RAND; i++) rand_reqs[i] = random_req(seed);
      bp_on <= 1'b1;
      for (int i = 0; i < N_RAND; i++) send_req(rand_reqs[i]);
      bp_on <= 1'b0;
      wait_for_responses();
      repeat (4) @(negedge i_clk);

      assert (n_checked == N_REQ) else begin
         $display("%0d requests sent but %0d responses checked", N_REQ, n_checked);
         err_cnt++;
      end
      $display("summary: %0d responses checked, %0d errors", n_checked, err_cnt);
      if (err_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== serial_agu_top.f ====
+incdir+sim
source/agu_types_pkg.sv
source/serial_ctl_pkg.sv
source/req_unpacker.sv
source/serial_sequencer.sv
source/serial_bufreg.sv
source/result_port.sv
source/serial_agu_top.sv
sim/tb_serial_agu_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_serial_agu_top \
		-f serial_agu_top.f --Mdir obj_dir -o tb_serial_agu_top
	./obj_dir/tb_serial_agu_top | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
